// File: verilog/axil_sram_pkg.sv
`default_nettype none

package axil_sram_pkg;

  // bus geometry of the AXI4-Lite slave port
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;

  // the memory holds 1024 words of 32 bits, so 4 KiB in total
  localparam int mem_addr_width = 10;
  localparam logic [addr_width-1:0] mem_bytes = strb_width * (2 ** mem_addr_width);

  // AXI response codes used by the slave
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // the two error opcodes carry a request that failed the range check,
  // so the controller answers it without touching the memory
  typedef enum logic [1:0] {
    op_write     = 2'd0,
    op_read      = 2'd1,
    op_err_write = 2'd2,
    op_err_read  = 2'd3
  } mem_op_e;

  // one queued memory access, strobes are active high as on the bus
  typedef struct packed {
    mem_op_e                   op;
    logic [mem_addr_width-1:0] word_addr;
    logic [data_width-1:0]     wdata;
    logic [strb_width-1:0]     wstrb;
  } mem_req_t;

  // states of the memory port controller
  typedef enum logic [1:0] {
    st_idle      = 2'd0,
    st_read_wait = 2'd1,
    st_resp      = 2'd2
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: verilog/generic_memory.sv
`default_nettype none

module generic_memory #(
  parameter int ADDR_WIDTH = 12,
  parameter int DATA_WIDTH = 32
) (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    cen,
  input  logic                    wen,
  input  logic [ADDR_WIDTH-1:0]   a,
  input  logic [DATA_WIDTH-1:0]   d,
  input  logic [DATA_WIDTH/8-1:0] ben,
  output logic [DATA_WIDTH-1:0]   q
);

  localparam int be_width  = DATA_WIDTH / 8;
  localparam int num_words = 2 ** ADDR_WIDTH;

  // contents are undefined until the first write to a word
  logic [DATA_WIDTH-1:0] mem [num_words];

  // all enables are active low, and the whole port is ignored in reset
  always_ff @(posedge CLK)
  begin
    if (rst_n && !cen)
    begin
      if (!wen)
      begin
        // only the bytes whose enable is low are written
        for (int i = 0; i < be_width; i++)
        begin
          if (!ben[i])
          begin
            mem[a][i*8 +: 8] <= d[i*8 +: 8];
          end
        end
      end
      else
      begin
        // q keeps the last read word until the next read access
        q <= mem[a];
      end
    end
  end

  // an access with an unknown address would corrupt or read an arbitrary word
  a_addr_known : assert property (
    @(posedge CLK) disable iff (!rst_n)
    !cen |-> !$isunknown(a)
  );

  // a write with unknown byte enables leaves the stored word undefined
  a_ben_known : assert property (
    @(posedge CLK) disable iff (!rst_n)
    (!cen && !wen) |-> !$isunknown(ben)
  );

endmodule

`default_nettype wire

// File: verilog/axil_req_decoder.sv
`default_nettype none

module axil_req_decoder (
  input  logic                                     CLK,
  input  logic                                     rst_n,
  input  logic                                     awvalid,
  output logic                                     awready,
  input  logic [axil_sram_pkg::addr_width-1:0]     awaddr,
  input  logic                                     wvalid,
  output logic                                     wready,
  input  logic [axil_sram_pkg::data_width-1:0]     wdata,
  input  logic [axil_sram_pkg::strb_width-1:0]     wstrb,
  input  logic                                     arvalid,
  output logic                                     arready,
  input  logic [axil_sram_pkg::addr_width-1:0]     araddr,
  output logic                                     push_valid,
  input  logic                                     push_ready,
  output axil_sram_pkg::mem_req_t                  push_req
);

  // a write is only taken when address and data arrive together
  logic wr_pending;
  logic rd_pending;
  logic take_wr;
  logic take_rd;
  // set when the last accepted request was a read
  logic last_was_read;
  logic aw_out_of_range;
  logic ar_out_of_range;

  assign wr_pending = awvalid && wvalid;
  assign rd_pending = arvalid;

  // when both kinds wait, the kind that was not served last time goes first
  assign take_wr = push_ready && wr_pending && (!rd_pending || last_was_read);
  assign take_rd = push_ready && rd_pending && !take_wr;

  // the ready signals double as the push, so the request lands in the FIFO
  // at the same edge as the bus handshake
  assign awready    = take_wr;
  assign wready     = take_wr;
  assign arready    = take_rd;
  assign push_valid = take_wr || take_rd;

  // anything at or past the end of the memory is answered with SLVERR
  assign aw_out_of_range = awaddr >= axil_sram_pkg::mem_bytes;
  assign ar_out_of_range = araddr >= axil_sram_pkg::mem_bytes;

  always_comb
  begin
    push_req.wdata = wdata;
    if (take_wr)
    begin
      push_req.op        = aw_out_of_range ? axil_sram_pkg::op_err_write
                                           : axil_sram_pkg::op_write;
      push_req.word_addr = awaddr[axil_sram_pkg::mem_addr_width+1:2];
      push_req.wstrb     = wstrb;
    end
    else
    begin
      // reads carry no strobes, the data field is simply don't-care
      push_req.op        = ar_out_of_range ? axil_sram_pkg::op_err_read
                                           : axil_sram_pkg::op_read;
      push_req.word_addr = araddr[axil_sram_pkg::mem_addr_width+1:2];
      push_req.wstrb     = '0;
    end
  end

  // fairness flag, starts as if a read was served so a write wins first
  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      last_was_read <= 1'b1;
    end
    else if (take_wr)
    begin
      last_was_read <= 1'b0;
    end
    else if (take_rd)
    begin
      last_was_read <= 1'b1;
    end
  end

  // a read that keeps losing must get the port on the next free cycle
  a_read_not_starved : assert property (
    @(posedge CLK) disable iff (!rst_n)
    (take_wr && rd_pending) ##1 (push_ready && rd_pending) |-> take_rd
  );

endmodule

`default_nettype wire

// File: verilog/mem_req_fifo.sv
`default_nettype none

module mem_req_fifo (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    push_valid,
  output logic                    push_ready,
  input  axil_sram_pkg::mem_req_t push_req,
  output logic                    pop_valid,
  input  logic                    pop_ready,
  output axil_sram_pkg::mem_req_t pop_req
);

  // two slots, addressed by one-bit pointers that wrap naturally
  axil_sram_pkg::mem_req_t slots [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       do_push;
  logic       do_pop;

  assign push_ready = count != 2'd2;
  assign pop_valid  = count != 2'd0;

  // the head entry is shown straight from the slot, no output register
  assign pop_req = slots[rd_ptr];

  assign do_push = push_valid && push_ready;
  assign do_pop  = pop_valid && pop_ready;

  // slot contents need no reset, count alone says which ones are live
  always_ff @(posedge CLK)
  begin
    if (do_push)
    begin
      slots[wr_ptr] <= push_req;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= !wr_ptr;
      end
      if (do_pop)
      begin
        rd_ptr <= !rd_ptr;
      end
      // a push and a pop in one cycle leave the count unchanged
      count <= count + {1'b0, do_push} - {1'b0, do_pop};
    end
  end

  // the decoder must look at push_ready before it offers a request
  a_no_push_full : assert property (
    @(posedge CLK) disable iff (!rst_n)
    push_valid |-> count != 2'd2
  );

  // the controller only asks for an entry when one is present
  a_no_pop_empty : assert property (
    @(posedge CLK) disable iff (!rst_n)
    pop_ready |-> count != 2'd0
  );

endmodule

`default_nettype wire

// File: verilog/mem_port_ctrl.sv
`default_nettype none

module mem_port_ctrl (
  input  logic                                         CLK,
  input  logic                                         rst_n,
  input  logic                                         pop_valid,
  output logic                                         pop_ready,
  input  axil_sram_pkg::mem_req_t                      pop_req,
  output logic                                         cen,
  output logic                                         wen,
  output logic [axil_sram_pkg::strb_width-1:0]         ben,
  output logic [axil_sram_pkg::mem_addr_width-1:0]     a,
  output logic [axil_sram_pkg::data_width-1:0]         d,
  input  logic [axil_sram_pkg::data_width-1:0]         q,
  output logic                                         bvalid,
  input  logic                                         bready,
  output logic [1:0]                                   bresp,
  output logic                                         rvalid,
  input  logic                                         rready,
  output logic [1:0]                                   rresp,
  output logic [axil_sram_pkg::data_width-1:0]         rdata
);

  axil_sram_pkg::ctrl_state_e state;
  axil_sram_pkg::mem_op_e     head_op;
  logic pop_fire;
  logic resp_done;
  logic mem_access;

  assign head_op = pop_req.op;

  // only idle takes a new request, so one response is outstanding at most
  assign pop_ready = (state == axil_sram_pkg::st_idle) && pop_valid;
  assign pop_fire  = pop_valid && pop_ready;
  assign resp_done = (bvalid && bready) || (rvalid && rready);

  // error opcodes never reach the memory
  assign mem_access = pop_fire && (head_op == axil_sram_pkg::op_write ||
                                   head_op == axil_sram_pkg::op_read);

  // the memory sees the FIFO head directly and acts at the pop edge
  assign cen = !mem_access;
  assign wen = head_op != axil_sram_pkg::op_write;
  assign ben = ~pop_req.wstrb;
  assign a   = pop_req.word_addr;
  assign d   = pop_req.wdata;

  always_ff @(posedge CLK)
  begin
    if (!rst_n)
    begin
      state  <= axil_sram_pkg::st_idle;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end
    else
    begin
      case (state)
        axil_sram_pkg::st_idle:
        begin
          if (pop_fire)
          begin
            case (head_op)
              // q is not valid until one cycle after the access
              axil_sram_pkg::op_read:
              begin
                state <= axil_sram_pkg::st_read_wait;
              end
              axil_sram_pkg::op_err_read:
              begin
                state  <= axil_sram_pkg::st_resp;
                rvalid <= 1'b1;
              end
              default:
              begin
                state  <= axil_sram_pkg::st_resp;
                bvalid <= 1'b1;
              end
            endcase
          end
        end
        axil_sram_pkg::st_read_wait:
        begin
          state  <= axil_sram_pkg::st_resp;
          rvalid <= 1'b1;
        end
        axil_sram_pkg::st_resp:
        begin
          // hold the response until the master takes it
          if (resp_done)
          begin
            state  <= axil_sram_pkg::st_idle;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
          end
        end
        default:
        begin
          state <= axil_sram_pkg::st_idle;
        end
      endcase
    end
  end

  // response payload is only written while no response is pending
  always_ff @(posedge CLK)
  begin
    if (pop_fire)
    begin
      bresp <= (head_op == axil_sram_pkg::op_err_write) ? axil_sram_pkg::resp_slverr
                                                        : axil_sram_pkg::resp_okay;
      rresp <= (head_op == axil_sram_pkg::op_err_read) ? axil_sram_pkg::resp_slverr
                                                       : axil_sram_pkg::resp_okay;
      rdata <= '0;
    end
    else if (state == axil_sram_pkg::st_read_wait)
    begin
      rdata <= q;
    end
  end

  a_one_response : assert property (
    @(posedge CLK) disable iff (!rst_n)
    !(bvalid && rvalid)
  );

  // a stalled read response must not change under the master
  a_r_stable : assert property (
    @(posedge CLK) disable iff (!rst_n)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp))
  );

endmodule

`default_nettype wire

// File: verilog/axil_sram_top.sv
`default_nettype none

module axil_sram_top (
  input  logic                                     CLK,
  input  logic                                     rst_n,
  input  logic                                     awvalid,
  output logic                                     awready,
  input  logic [axil_sram_pkg::addr_width-1:0]     awaddr,
  input  logic [2:0]                               awprot,
  input  logic                                     wvalid,
  output logic                                     wready,
  input  logic [axil_sram_pkg::data_width-1:0]     wdata,
  input  logic [axil_sram_pkg::strb_width-1:0]     wstrb,
  output logic                                     bvalid,
  input  logic                                     bready,
  output logic [1:0]                               bresp,
  input  logic                                     arvalid,
  output logic                                     arready,
  input  logic [axil_sram_pkg::addr_width-1:0]     araddr,
  input  logic [2:0]                               arprot,
  output logic                                     rvalid,
  input  logic                                     rready,
  output logic [axil_sram_pkg::data_width-1:0]     rdata,
  output logic [1:0]                               rresp
);

  // awprot and arprot are part of the port only, every access is allowed

  // decoder to FIFO
  logic                    push_valid;
  logic                    push_ready;
  axil_sram_pkg::mem_req_t push_req;

  // FIFO to controller
  logic                    pop_valid;
  logic                    pop_ready;
  axil_sram_pkg::mem_req_t pop_req;

  // controller to memory, all enables active low
  logic                                     cen;
  logic                                     wen;
  logic [axil_sram_pkg::strb_width-1:0]     ben;
  logic [axil_sram_pkg::mem_addr_width-1:0] a;
  logic [axil_sram_pkg::data_width-1:0]     d;
  logic [axil_sram_pkg::data_width-1:0]     q;

  axil_req_decoder u_decoder (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_req   (push_req)
  );

  mem_req_fifo u_fifo (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_req   (push_req),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_req    (pop_req)
  );

  mem_port_ctrl u_ctrl (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_req   (pop_req),
    .cen       (cen),
    .wen       (wen),
    .ben       (ben),
    .a         (a),
    .d         (d),
    .q         (q),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .rresp     (rresp),
    .rdata     (rdata)
  );

  generic_memory #(
    .ADDR_WIDTH (axil_sram_pkg::mem_addr_width),
    .DATA_WIDTH (axil_sram_pkg::data_width)
  ) u_mem (
    .CLK   (CLK),
    .rst_n (rst_n),
    .cen   (cen),
    .wen   (wen),
    .a     (a),
    .d     (d),
    .ben   (ben),
    .q     (q)
  );

endmodule

`default_nettype wire

// File: verif/axil_sram_tb.sv
`default_nettype none

module axil_sram_tb;

  // every test below issues this many bus transactions in total
  localparam int planned_txns    = 91;
  localparam int watchdog_cycles = planned_txns * 200;
  localparam int mem_size        = axil_sram_pkg::mem_bytes;

  // one expected response, queued in the order the DUT accepts requests
  typedef struct packed {
    logic        is_read;
    logic [1:0]  resp;
    logic [31:0] data;
    logic [31:0] mask;
  } expect_t;

  logic        CLK;
  logic        rst_n;
  logic        awvalid;
  logic        awready;
  logic [31:0] awaddr;
  logic [2:0]  awprot;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [31:0] araddr;
  logic [2:0]  arprot;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;

  // byte model of the memory, a byte counts only once it has been written
  logic [7:0] model_mem [mem_size];
  logic       model_known [mem_size];
  expect_t    exp_q [$];
  logic [31:0] rng_state;
  int         check_count;
  int         error_count;

  axil_sram_top DUT (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .awprot  (awprot),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .arprot  (arprot),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
  );

  initial
  begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (expected === actual)
    else
    begin
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic flag_failure(input string msg);
    $display("%s", msg);
    error_count++;
  endtask

  // a write updates the model at acceptance, since the DUT keeps request order
  task automatic record_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
    expect_t e;
    int      base;
    e.is_read = 1'b0;
    e.data    = '0;
    e.mask    = '0;
    e.resp    = axil_sram_pkg::resp_slverr;
    if (addr < axil_sram_pkg::mem_bytes)
    begin
      e.resp = axil_sram_pkg::resp_okay;
      base   = int'({addr[31:2], 2'b00});
      for (int i = 0; i < 4; i++)
      begin
        if (strb[i])
        begin
          model_mem[base+i]   = data[i*8 +: 8];
          model_known[base+i] = 1'b1;
        end
      end
    end
    exp_q.push_back(e);
  endtask

  // unwritten bytes are left out of the compare through the mask
  task automatic expect_read(input logic [31:0] addr);
    expect_t e;
    int      base;
    e.is_read = 1'b1;
    e.data    = '0;
    e.mask    = '0;
    e.resp    = axil_sram_pkg::resp_slverr;
    if (addr < axil_sram_pkg::mem_bytes)
    begin
      e.resp = axil_sram_pkg::resp_okay;
      base   = int'({addr[31:2], 2'b00});
      for (int i = 0; i < 4; i++)
      begin
        if (model_known[base+i])
        begin
          e.data[i*8 +: 8] = model_mem[base+i];
          e.mask[i*8 +: 8] = 8'hff;
        end
      end
    end
    exp_q.push_back(e);
  endtask

  task automatic issue_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    @(posedge CLK);
    while (!(awready && wready))
    begin
      @(posedge CLK);
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    record_write(addr, data, strb);
  endtask

  task automatic issue_read(input logic [31:0] addr);
    arvalid <= 1'b1;
    araddr  <= addr;
    @(posedge CLK);
    while (!arready)
    begin
      @(posedge CLK);
    end
    arvalid <= 1'b0;
    expect_read(addr);
  endtask

  // both channels wait together, the order of acceptance sets the expected order
  task automatic offer_pair(input logic [31:0] waddr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [31:0] raddr);
    logic wr_done;
    logic rd_done;
    wr_done = 1'b0;
    rd_done = 1'b0;
    awvalid <= 1'b1;
    awaddr  <= waddr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    arvalid <= 1'b1;
    araddr  <= raddr;
    while (!(wr_done && rd_done))
    begin
      @(posedge CLK);
      if (!wr_done && awready && wready)
      begin
        wr_done = 1'b1;
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        record_write(waddr, data, strb);
      end
      if (!rd_done && arready)
      begin
        rd_done = 1'b1;
        arvalid <= 1'b0;
        expect_read(raddr);
      end
    end
  endtask

  // takes n responses of either kind and compares each with the queue head
  task automatic drain_responses(input int n);
    expect_t e;
    int      got;
    got = 0;
    while (got < n)
    begin
      @(posedge CLK);
      if ((bvalid && bready) || (rvalid && rready))
      begin
        got++;
        if (exp_q.size() == 0)
        begin
          flag_failure("a response arrived while no request was outstanding");
        end
        else
        begin
          e = exp_q.pop_front();
          check_value("rvalid", {31'b0, e.is_read}, {31'b0, rvalid});
          if (e.is_read)
          begin
            check_value("rresp", {30'b0, e.resp}, {30'b0, rresp});
            check_value("rdata", e.data & e.mask, rdata & e.mask);
          end
          else
          begin
            check_value("bresp", {30'b0, e.resp}, {30'b0, bresp});
          end
        end
      end
    end
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    issue_write(addr, data, strb);
    drain_responses(1);
  endtask

  task automatic axil_read(input logic [31:0] addr);
    issue_read(addr);
    drain_responses(1);
  endtask

  task automatic full_word_roundtrip();
    axil_write(32'h0000_0100, 32'hdead_beef, 4'hf);
    axil_read(32'h0000_0100);
  endtask

  // each partial write replaces only its strobed bytes of the word
  task automatic strobe_merge();
    axil_write(32'h0000_0200, 32'h0123_4567, 4'hf);
    axil_write(32'h0000_0200, 32'haaaa_aaaa, 4'b0001);
    axil_read(32'h0000_0200);
    axil_write(32'h0000_0200, 32'hbbbb_bbbb, 4'b0110);
    axil_read(32'h0000_0200);
    axil_write(32'h0000_0200, 32'hcccc_cccc, 4'b1000);
    axil_read(32'h0000_0200);
    axil_write(32'h0000_0200, 32'h1d2d_3d4d, 4'b1010);
    axil_read(32'h0000_0200);
  endtask

  // the write at mem_bytes + 0x100 would alias word 0x100 if it got through
  task automatic out_of_range_slverr();
    axil_write(axil_sram_pkg::mem_bytes, 32'h5555_5555, 4'hf);
    axil_write(axil_sram_pkg::mem_bytes + 32'h100, 32'h6666_6666, 4'hf);
    axil_read(axil_sram_pkg::mem_bytes);
    axil_read(32'hffff_fffc);
    axil_read(32'h0000_0100);
  endtask

  task automatic response_backpressure();
    expect_t head;
    bready <= 1'b0;
    rready <= 1'b0;
    // one write ends up waiting on B, two more requests fill the FIFO
    issue_write(32'h0000_0300, 32'h1111_2222, 4'hf);
    issue_read(32'h0000_0300);
    issue_write(32'h0000_0304, 32'h3333_4444, 4'hf);
    awvalid <= 1'b1;
    awaddr  <= 32'h0000_0308;
    wvalid  <= 1'b1;
    wdata   <= 32'h7777_8888;
    wstrb   <= 4'hf;
    arvalid <= 1'b1;
    araddr  <= 32'h0000_0304;
    for (int i = 0; i < 6; i++)
    begin
      @(posedge CLK);
      // the stalled B response belongs to the oldest outstanding request
      head = exp_q[0];
      check_value("awready", 32'd0, {31'b0, awready});
      check_value("wready", 32'd0, {31'b0, wready});
      check_value("arready", 32'd0, {31'b0, arready});
      check_value("bvalid", 32'd1, {31'b0, bvalid});
      check_value("bresp", {30'b0, head.resp}, {30'b0, bresp});
    end
    bready <= 1'b1;
    rready <= 1'b1;
    fork
      offer_pair(32'h0000_0308, 32'h7777_8888, 4'hf, 32'h0000_0304);
      drain_responses(5);
    join
    // now a read response waits on R
    rready <= 1'b0;
    issue_read(32'h0000_0308);
    while (!rvalid)
    begin
      @(posedge CLK);
    end
    head = exp_q[0];
    repeat (5)
    begin
      @(posedge CLK);
      check_value("rvalid", 32'd1, {31'b0, rvalid});
      check_value("rdata", head.data & head.mask, rdata & head.mask);
      check_value("rresp", {30'b0, head.resp}, {30'b0, rresp});
    end
    rready <= 1'b1;
    drain_responses(1);
  endtask

  // a read ahead of the second pair flips the fairness flag, so that pair
  // runs in the other order with the write accepted first
  task automatic simultaneous_write_read();
    axil_write(32'h0000_0400, 32'h0f0f_0f0f, 4'hf);
    offer_pair(32'h0000_0400, 32'hcafe_f00d, 4'hf, 32'h0000_0400);
    drain_responses(2);
    axil_read(32'h0000_0400);
    offer_pair(32'h0000_0400, 32'h0bad_1dea, 4'b0011, 32'h0000_0400);
    drain_responses(2);
  endtask

  // random traffic over 16 words, so reads mostly hit written bytes
  task automatic random_mix();
    logic [31:0] r;
    logic [31:0] addr;
    for (int n = 0; n < 64; n++)
    begin
      rng_state = xorshift32(rng_state);
      r         = rng_state;
      addr      = 32'h0000_0800 + {26'b0, r[7:4], 2'b00};
      if (r[0])
      begin
        axil_read(addr);
      end
      else
      begin
        rng_state = xorshift32(rng_state);
        axil_write(addr, rng_state, r[11:8]);
      end
    end
  endtask

  initial
  begin
    rst_n       = 1'b0;
    awvalid     = 1'b0;
    awaddr      = '0;
    awprot      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    bready      = 1'b1;
    arvalid     = 1'b0;
    araddr      = '0;
    arprot      = '0;
    rready      = 1'b1;
    rng_state   = 32'hf63d_70fb;
    check_count = 0;
    error_count = 0;
    for (int i = 0; i < mem_size; i++)
    begin
      model_known[i] = 1'b0;
    end
    repeat (2) @(posedge CLK);
    rst_n <= 1'b1;
    @(posedge CLK);
    // nothing may be ready or valid straight out of reset
    check_value("awready", 32'd0, {31'b0, awready});
    check_value("wready", 32'd0, {31'b0, wready});
    check_value("arready", 32'd0, {31'b0, arready});
    check_value("bvalid", 32'd0, {31'b0, bvalid});
    check_value("rvalid", 32'd0, {31'b0, rvalid});
    full_word_roundtrip();
    strobe_merge();
    out_of_range_slverr();
    response_backpressure();
    simultaneous_write_read();
    random_mix();
    if (exp_q.size() != 0)
    begin
      flag_failure("some expected responses never arrived");
    end
    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

  // bounds the run in case a handshake or response never comes
  initial
  begin
    repeat (watchdog_cycles) @(posedge CLK);
    $display("timeout: tests still running after %0d cycles", watchdog_cycles);
    $display("checks run: %0d, errors: %0d", check_count, error_count);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
verilog/axil_sram_pkg.sv
verilog/generic_memory.sv
verilog/axil_req_decoder.sv
verilog/mem_req_fifo.sv
verilog/mem_port_ctrl.sv
verilog/axil_sram_top.sv
verif/axil_sram_tb.sv

// File: Makefile
# Verilator build and run of the AXI4-Lite SRAM testbench

# the binary is rebuilt only when the file list or a source changes
obj_dir/Vaxil_sram_tb: sim.f $(wildcard verilog/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -j 0 --top-module axil_sram_tb -f sim.f

.PHONY: run clean

# pass or fail comes from the pass line in the simulator output
run: obj_dir/Vaxil_sram_tb
	@out="$$(./obj_dir/Vaxil_sram_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Done: no errors'

clean:
	rm -rf obj_dir
